// File: Bender.yml
package:
  name: trigger_out

sources:
  - rtl/trig_pkg.sv
  - rtl/hit_or_tree.sv
  - rtl/trigger_group_select.sv
  - rtl/output_shaper.sv
  - rtl/trigger_out_top.sv
  - target: simulation
    files:
      - bench/trigger_out_sva.sv
      - bench/trigger_out_tb.sv

// File: bench/trigger_out_sva.sv
module trigger_out_sva import trig_pkg::*; (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic output_reset,
	input logic [time_bits-1:0] hightime,
	input logic pulse,
	input shaper_state_t state_q
);

	// failures so far, the testbench adds them to its summary
	int fail_count = 0;
	// number of edges pulse has been seen high in a row
	logic [time_bits:0] high_run;

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start || !pulse) begin
			high_run <= '0;
		end else begin
			high_run <= high_run + 1'b1;
		end
	end

	// --------------------------------------------------
	// shaper rules
	// --------------------------------------------------

	// pulse is high exactly in st_high
	state_pulse: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
		pulse == (state_q == st_high))
		else begin
			fail_count++;
			$error("shaper pulse does not match its state");
		end

	// a pulse that ends on its own lasted hightime+1 cycles
	pulse_width: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
		$fell(pulse) && !$past(output_reset) |-> high_run == hightime + 1)
		else begin
			fail_count++;
			$error("shaper pulse lasted %0d cycles, hightime is %0d", high_run, hightime);
		end

	// output_reset leaves no pulse in the following cycle
	reset_clears: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
		output_reset |=> !pulse)
		else begin
			fail_count++;
			$error("shaper pulse still high after output_reset");
		end

endmodule

bind output_shaper trigger_out_sva sva_i (
	.CLK200(CLK200),
	.tdc_reset_start(tdc_reset_start),
	.output_reset(output_reset),
	.hightime(hightime),
	.pulse(pulse),
	.state_q(state_q)
);

// File: bench/trigger_out_tb.sv
module trigger_out_tb import trig_pkg::*; ();

	// --------------------------------------------------
	// constants, DUT signals and recording windows
	// --------------------------------------------------

	localparam int clk_period = 8;
	localparam int reset_cycles = 16;
	// edges per window, enough for the longest pulse plus dead time
	localparam int win_len = 48;
	localparam int n_windows = 12;
	// trig_level settles after hit_latency edges, the shaper flop adds one
	localparam int rise_delay = hit_latency + 1;
	localparam int chan_per_mez = n_channels / n_mez;
	localparam int watchdog_time =
		2 * n_windows * (win_len + 1) * clk_period + reset_cycles * clk_period;

	logic CLK200;
	logic tdc_reset_start;
	logic [n_channels-1:0] hits;
	logic [n_channels-1:0] enable;
	trig_cfg_t cfg;
	logic output_reset;
	logic [n_trig_out-1:0] trig_out;

	// hit vector and output_reset per sampling edge
	logic [n_channels-1:0] stim [win_len];
	logic orst [win_len];
	// trig_out seen after each edge, and the predicted value
	logic [n_trig_out-1:0] obs [win_len];
	logic [n_trig_out-1:0] expv [win_len];

	logic [31:0] rng;
	int error_count;
	int check_count;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	int sva_failures;

	trigger_out_top dut_i (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.hits(hits),
		.enable(enable),
		.cfg(cfg),
		.output_reset(output_reset),
		.trig_out(trig_out)
	);

	initial begin
		CLK200 = 1'b0;
		forever begin
			#(clk_period / 2) CLK200 = ~CLK200;
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	// random channel inside mezzanine mez
	task automatic pick_channel(input int mez, output int chan);
		rng = xorshift32(rng);
		chan = mez * chan_per_mez + int'(rng % chan_per_mez);
	endtask

	task automatic set_cfg(input logic [n_mez-1:0] g0, input logic [n_mez-1:0] g1,
			input int h, input int dt);
		cfg.group_0 = g0;
		cfg.group_1 = g1;
		cfg.hightime = time_bits'(h);
		cfg.deadtime = time_bits'(dt);
	endtask

	task automatic clear_stimulus();
		for (int k = 0; k < win_len; k++) begin
			stim[k] = '0;
			orst[k] = 1'b0;
		end
	endtask

	task automatic add_hit(input int chan, input int first, input int len);
		for (int k = first; k < first + len; k++) begin
			stim[k][chan] = 1'b1;
		end
	endtask

	task automatic check_value(input string name, input string what,
			input logic [31:0] got, input logic [31:0] want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("ERROR %s: %s is %h, expected %h", name, what, got, want);
		end
	endtask

	// outputs a hit vector reaches: mezzanine is c/32, gated by the group masks
	function automatic logic [n_trig_out-1:0] outputs_hit(input logic [n_channels-1:0] v);
		logic [n_trig_out-1:0] o;
		o = '0;
		for (int c = 0; c < n_channels; c++) begin
			if (v[c] && enable[c]) begin
				o[0] = o[0] | cfg.group_0[c / chan_per_mez];
				o[1] = o[1] | cfg.group_1[c / chan_per_mez];
			end
		end
		return o;
	endfunction

	function automatic logic [n_trig_out-1:0] fired_outputs();
		logic [n_trig_out-1:0] f;
		f = '0;
		for (int m = 0; m < win_len; m++) begin
			f = f | obs[m];
		end
		return f;
	endfunction

	// drive one window on falling edges, obs[k] is trig_out after edge k
	task automatic run_window();
		for (int k = 0; k <= win_len; k++) begin
			@(negedge CLK200);
			if (k > 0) begin
				obs[k-1] = trig_out;
			end
			hits = (k < win_len) ? stim[k] : '0;
			output_reset = (k < win_len) ? orst[k] : 1'b0;
		end
	endtask

	// expected pulse per output from the shaper timing rule
	task automatic predict_and_compare(input string name);
		logic [n_trig_out-1:0] lvl;
		logic d;
		int next_ok;
		int hi_end;
		for (int o = 0; o < n_trig_out; o++) begin
			next_ok = 0;
			hi_end = -1;
			for (int m = 0; m < win_len; m++) begin
				lvl = (m >= rise_delay) ? outputs_hit(stim[m - rise_delay]) : '0;
				d = lvl[o];
				if (orst[m]) begin
					// shaper back in idle, may fire on the next edge
					expv[m][o] = 1'b0;
					hi_end = -1;
					next_ok = m + 1;
				end else if (d && m >= next_ok) begin
					// hightime+1 high, deadtime+1 dead, one edge back to idle
					expv[m][o] = 1'b1;
					hi_end = m + cfg.hightime;
					next_ok = m + cfg.hightime + cfg.deadtime + 3;
				end else begin
					expv[m][o] = (m <= hi_end);
				end
			end
		end
		for (int m = 0; m < win_len; m++) begin
			check_value(name, $sformatf("trig_out after edge %0d", m), obs[m], expv[m]);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (error_count != test_start_errors) begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, error_count - test_start_errors);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic test_reset_state();
		test_start_errors = error_count;
		// every hit active while reset is held
		hits = '1;
		enable = '1;
		set_cfg(3'b111, 3'b111, 3, 3);
		repeat (reset_cycles) begin
			@(negedge CLK200);
			check_value("reset_state", "trig_out during reset", trig_out, 0);
		end
		tdc_reset_start = 1'b0;
		hits = '0;
		clear_stimulus();
		run_window();
		predict_and_compare("reset_state");
		end_test("reset_state");
	endtask

	task automatic test_latency_width();
		int ch;
		int rise;
		int width;
		test_start_errors = error_count;
		set_cfg(3'b001, 3'b100, 3, 5);
		enable = '1;
		pick_channel(0, ch);
		clear_stimulus();
		add_hit(ch, 0, 1);
		run_window();
		rise = -1;
		width = 0;
		for (int m = 0; m < win_len; m++) begin
			if (obs[m][0] === 1'b1) begin
				width++;
				rise = (rise < 0) ? m : rise;
			end
		end
		check_value("latency_width", "trig_out[0] rise edge", rise, rise_delay);
		check_value("latency_width", "trig_out[0] high cycles", width, cfg.hightime + 1);
		predict_and_compare("latency_width");
		end_test("latency_width");
	endtask

	task automatic test_group_select();
		// three mask pairs, pair 0 in the low bits
		logic [3*n_mez-1:0] masks_0;
		logic [3*n_mez-1:0] masks_1;
		int ch;
		test_start_errors = error_count;
		masks_0 = {3'b101, 3'b110, 3'b010};
		masks_1 = {3'b011, 3'b001, 3'b100};
		enable = '1;
		for (int p = 0; p < 3; p++) begin
			// mezzanines B and C
			for (int z = 1; z < n_mez; z++) begin
				set_cfg(masks_0[p*n_mez +: n_mez], masks_1[p*n_mez +: n_mez], 2, 2);
				pick_channel(z, ch);
				clear_stimulus();
				add_hit(ch, 0, 2);
				run_window();
				check_value("group_select", $sformatf("trig_out fired for channel %0d", ch),
					fired_outputs(), {cfg.group_1[z], cfg.group_0[z]});
				predict_and_compare("group_select");
			end
		end
		end_test("group_select");
	endtask

	task automatic test_enable_mask();
		int ch;
		test_start_errors = error_count;
		set_cfg(3'b111, 3'b111, 2, 3);
		pick_channel(int'(rng % n_mez), ch);
		enable = '1;
		enable[ch] = 1'b0;
		clear_stimulus();
		add_hit(ch, 0, 1);
		run_window();
		check_value("enable_mask", "trig_out fired, channel disabled", fired_outputs(), 0);
		predict_and_compare("enable_mask");
		enable[ch] = 1'b1;
		run_window();
		check_value("enable_mask", "trig_out fired, channel enabled", fired_outputs(), 3);
		predict_and_compare("enable_mask");
		end_test("enable_mask");
	endtask

	task automatic test_dead_time();
		int ch;
		int n_rise;
		int rises [2];
		test_start_errors = error_count;
		set_cfg(3'b111, 3'b000, 2, 4);
		enable = '1;
		pick_channel(int'(rng % n_mez), ch);
		clear_stimulus();
		add_hit(ch, 0, 1);
		// reaches the shaper in the middle of its dead time
		add_hit(ch, 5, 1);
		// first cycle lands on the edge back to idle, second one fires
		add_hit(ch, 8, 2);
		run_window();
		n_rise = 0;
		rises = '{-1, -1};
		for (int m = 1; m < win_len; m++) begin
			if (obs[m][0] === 1'b1 && obs[m-1][0] === 1'b0) begin
				rises[n_rise % 2] = m;
				n_rise++;
			end
		end
		check_value("dead_time", "trig_out[0] pulse count", n_rise, 2);
		check_value("dead_time", "trig_out[0] second rise edge", rises[1],
			rises[0] + cfg.hightime + cfg.deadtime + 3);
		predict_and_compare("dead_time");
		end_test("dead_time");
	endtask

	task automatic test_output_reset();
		int ch;
		test_start_errors = error_count;
		set_cfg(3'b111, 3'b111, 7, 3);
		enable = '1;
		pick_channel(int'(rng % n_mez), ch);
		clear_stimulus();
		add_hit(ch, 0, 1);
		// pulse is high after edges 6 to 13, cut at edge 8
		orst[8] = 1'b1;
		add_hit(ch, 12, 1);
		run_window();
		check_value("output_reset", "trig_out before output_reset", obs[7], 3);
		check_value("output_reset", "trig_out after output_reset", obs[8], 0);
		check_value("output_reset", "trig_out on the later hit", obs[12 + rise_delay], 3);
		predict_and_compare("output_reset");
		end_test("output_reset");
	endtask

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------

	initial begin
		tdc_reset_start = 1'b1;
		hits = '0;
		enable = '0;
		cfg = '0;
		output_reset = 1'b0;
		rng = 32'h8785;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		test_reset_state();
		test_latency_width();
		test_group_select();
		test_enable_mask();
		test_dead_time();
		test_output_reset();
		sva_failures = dut_i.shaper_0.sva_i.fail_count + dut_i.shaper_1.sva_i.fail_count;
		if (sva_failures != 0) begin
			$display("shaper assertions failed %0d times", sva_failures);
			error_count += sva_failures;
		end
		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(watchdog_time);
		$display("timeout: tests still running after %0d time units", watchdog_time);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: rtl/hit_or_tree.sv
module hit_or_tree import trig_pkg::*; (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [n_channels-1:0] hits,
	input logic [n_channels-1:0] enable,
	output logic [n_mez-1:0] mez_or
);

	// sampled hits after masking (edge E0)
	logic [n_channels-1:0] hit_q;
	// 4 channel ORs (edge E1)
	logic [n_quads-1:0] quad_q;
	// half mezzanine ORs (edge E2)
	logic [n_halves-1:0] half_q;

	// --------------------------------------------------
	// sampling and masking
	// --------------------------------------------------

	// disabled channels are dropped right at the sampling edge
	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			hit_q <= '0;
		end else begin
			hit_q <= hits & enable;
		end
	end

	// --------------------------------------------------
	// registered OR tree
	// --------------------------------------------------

	// three register levels keep each OR narrow enough for 200 MHz
	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			quad_q <= '0;
			half_q <= '0;
			mez_or <= '0;
		end else begin
			// level 1: 24 groups of 4 channels
			for (int i = 0; i < n_quads; i++) begin
				quad_q[i] <= |hit_q[i*or_width +: or_width];
			end
			// level 2: 6 halves of 16 channels
			for (int j = 0; j < n_halves; j++) begin
				half_q[j] <= |quad_q[j*quads_per_half +: quads_per_half];
			end
			// level 3: one bit per mezzanine
			// bit 0 covers channels 0..31 (A), bit 2 channels 64..95 (C)
			for (int k = 0; k < n_mez; k++) begin
				mez_or[k] <= |half_q[k*halves_per_mez +: halves_per_mez];
			end
		end
	end

endmodule

// File: rtl/output_shaper.sv
module output_shaper import trig_pkg::*; (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic output_reset,
	input logic d,
	input logic [time_bits-1:0] hightime,
	input logic [time_bits-1:0] deadtime,
	output logic pulse
);

	// FSM state and the shared down counter
	shaper_state_t state_q;
	shaper_state_t state_d;
	logic [time_bits-1:0] cnt_q;
	logic [time_bits-1:0] cnt_d;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------

	// idle: wait for d
	// high: hightime+1 cycles with pulse set
	// dead: deadtime+1 cycles, d is ignored
	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		case (state_q)
			st_idle: begin
				if (d) begin
					// counter holds the remaining extra high cycles
					state_d = st_high;
					cnt_d = hightime;
				end
			end
			st_high: begin
				if (cnt_q == '0) begin
					state_d = st_dead;
					cnt_d = deadtime;
				end else begin
					cnt_d = cnt_q - 1'b1;
				end
			end
			st_dead: begin
				if (cnt_q == '0) begin
					// back to idle, a d still high fires on the next edge
					state_d = st_idle;
				end else begin
					cnt_d = cnt_q - 1'b1;
				end
			end
			default: begin
				// unused encoding, recover to idle
				state_d = st_idle;
				cnt_d = '0;
			end
		endcase
	end

	// --------------------------------------------------
	// state and output registers
	// --------------------------------------------------

	// pulse comes straight from a flop so the NIM driver sees no glitches
	// output_reset drops a running pulse on the next edge
	always_ff @(posedge CLK200) begin
		if (tdc_reset_start || output_reset) begin
			state_q <= st_idle;
			cnt_q <= '0;
			pulse <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
			// decoded from the next state, so pulse tracks st_high exactly
			pulse <= (state_d == st_high);
		end
	end

endmodule

// File: rtl/trig_pkg.sv
package trig_pkg;

	// --------------------------------------------------
	// channel geometry
	// --------------------------------------------------

	// number of data channels feeding the trigger
	localparam int n_channels = 96;
	// three LVDS mezzanines A to C with 32 channels each
	localparam int n_mez = 3;
	// first OR level groups 4 neighbouring channels
	localparam int or_width = 4;
	// half of one mezzanine
	localparam int chan_per_half = 16;

	// derived counts for the OR tree
	localparam int n_quads = n_channels / or_width;
	localparam int n_halves = n_channels / chan_per_half;
	localparam int quads_per_half = chan_per_half / or_width;
	localparam int halves_per_mez = n_halves / n_mez;

	// --------------------------------------------------
	// trigger outputs
	// --------------------------------------------------

	// two shaped NIM trigger outputs
	localparam int n_trig_out = 2;
	// width of the hightime and deadtime fields
	localparam int time_bits = 4;
	// edges from hit sampling up to the trig_level register
	localparam int hit_latency = 5;

	// configuration inputs of the trigger path
	// in each group mask bit 0 selects mezzanine A and bit 2 mezzanine C
	typedef struct packed {
		logic [n_mez-1:0] group_0;
		logic [n_mez-1:0] group_1;
		logic [time_bits-1:0] hightime;
		logic [time_bits-1:0] deadtime;
	} trig_cfg_t;

	// shaper states
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_high = 2'd1,
		st_dead = 2'd2
	} shaper_state_t;

endpackage

// File: rtl/trigger_group_select.sv
module trigger_group_select import trig_pkg::*; (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [n_mez-1:0] mez_or,
	input logic [n_mez-1:0] group_0,
	input logic [n_mez-1:0] group_1,
	output logic [n_trig_out-1:0] trig_level
);

	// group masks side by side, one row per output
	logic [n_trig_out-1:0][n_mez-1:0] group_mask;
	// gated mezzanine bits per output (edge E4)
	logic [n_trig_out-1:0][n_mez-1:0] choice_q;

	assign group_mask[0] = group_0;
	assign group_mask[1] = group_1;

	// --------------------------------------------------
	// stage 1: gate each mezzanine bit by the mask
	// --------------------------------------------------

	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			choice_q <= '0;
		end else begin
			for (int o = 0; o < n_trig_out; o++) begin
				// a cleared mask bit forces that mezzanine off
				choice_q[o] <= mez_or & group_mask[o];
			end
		end
	end

	// --------------------------------------------------
	// stage 2: OR the selected mezzanines
	// --------------------------------------------------

	// level signal, the shaper turns it into a pulse
	always_ff @(posedge CLK200) begin
		if (tdc_reset_start) begin
			trig_level <= '0;
		end else begin
			for (int o = 0; o < n_trig_out; o++) begin
				trig_level[o] <= |choice_q[o];
			end
		end
	end

endmodule

// File: rtl/trigger_out_top.sv
module trigger_out_top import trig_pkg::*; (
	input logic CLK200,
	input logic tdc_reset_start,
	input logic [n_channels-1:0] hits,
	input logic [n_channels-1:0] enable,
	input trig_cfg_t cfg,
	input logic output_reset,
	output logic [n_trig_out-1:0] trig_out
);

	// one bit per mezzanine, valid 3 edges after sampling
	logic [n_mez-1:0] mez_or;
	// selected trigger level per output
	logic [n_trig_out-1:0] trig_level;

	// --------------------------------------------------
	// hit masking and OR tree
	// --------------------------------------------------

	hit_or_tree or_tree_i (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.hits(hits),
		.enable(enable),
		.mez_or(mez_or)
	);

	// --------------------------------------------------
	// mezzanine group selection
	// --------------------------------------------------

	trigger_group_select group_sel_i (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.mez_or(mez_or),
		.group_0(cfg.group_0),
		.group_1(cfg.group_1),
		.trig_level(trig_level)
	);

	// --------------------------------------------------
	// pulse shapers, both share hightime and deadtime
	// --------------------------------------------------

	// trigger out A, NIM output 1 on the board
	output_shaper shaper_0 (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.output_reset(output_reset),
		.d(trig_level[0]),
		.hightime(cfg.hightime),
		.deadtime(cfg.deadtime),
		.pulse(trig_out[0])
	);

	// trigger out B, NIM output 3 on the board
	output_shaper shaper_1 (
		.CLK200(CLK200),
		.tdc_reset_start(tdc_reset_start),
		.output_reset(output_reset),
		.d(trig_level[1]),
		.hightime(cfg.hightime),
		.deadtime(cfg.deadtime),
		.pulse(trig_out[1])
	);

endmodule

// File: trigger_out.f
rtl/trig_pkg.sv
rtl/hit_or_tree.sv
rtl/trigger_group_select.sv
rtl/output_shaper.sv
rtl/trigger_out_top.sv
bench/trigger_out_sva.sv
bench/trigger_out_tb.sv
